// ==== Bender.yml ====
package:
  name: ray_core

sources:
  # design sources, also needed by the simulation target
  - target: any(rtl, sim)
    files:
      - rtl/ray_core_pkg.sv
      - rtl/pixel_stream_if.sv
      - rtl/surface_unit.sv
      - rtl/relay_stage.sv
      - rtl/ray_core.sv

  # testbench
  - target: sim
    files:
      - sim/tb_clock_gen.sv
      - sim/ray_core_tb.sv

// ==== rtl/pixel_stream_if.sv ====
// --------------------------------------------------
// pixel hand-off between two pipeline stages
// valid is a one-cycle pulse, full is the receiver's
// one-entry buffer state
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface pixel_stream_if
    import ray_core_pkg::*;
();

    // pulse from the sender, item moves on this edge
    logic   valid;
    // only meaningful while valid is high
    pixel_t data;
    // receiver buffer occupied
    logic   full;

    modport sender (
        output valid,
        output data,
        input  full
    );

    modport receiver (
        input  valid,
        input  data,
        output full
    );

endinterface

`default_nettype wire

// ==== rtl/ray_core.sv ====
// --------------------------------------------------
// ray pipeline core, surface -> shadow -> shade
// rays enter on in_valid/in_ray, pixels leave on
// out_valid/out_pixel, out_full stalls the last stage
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ray_core
    import ray_core_pkg::*;
#(
    // work cycles per ray in the surface stage
    parameter int SURF_DELAY = 16
) (
    input  wire     clk,
    input  wire     resetn,
    input  logic    in_valid,
    input  ray_in_t in_ray,
    output logic    in_full,
    output logic    out_valid,
    output pixel_t  out_pixel,
    input  logic    out_full
);

    // --------------------------------------------------
    // stage links
    // --------------------------------------------------
    pixel_stream_if surf_to_shadow ();
    pixel_stream_if shadow_to_shade ();

    // --------------------------------------------------
    // stages
    // --------------------------------------------------
    surface_unit #(
        .SURF_DELAY (SURF_DELAY)
    ) u_surface (
        .clk      (clk),
        .resetn   (resetn),
        .in_valid (in_valid),
        .in_ray   (in_ray),
        .in_full  (in_full),
        .out      (surf_to_shadow)
    );

    // middle stage, outputs land on the next link
    relay_stage u_shadow (
        .clk       (clk),
        .resetn    (resetn),
        .in        (surf_to_shadow),
        .out_valid (shadow_to_shade.valid),
        .out_pixel (shadow_to_shade.data),
        .out_full  (shadow_to_shade.full)
    );

    // last stage drives the core outputs
    relay_stage u_shade (
        .clk       (clk),
        .resetn    (resetn),
        .in        (shadow_to_shade),
        .out_valid (out_valid),
        .out_pixel (out_pixel),
        .out_full  (out_full)
    );

endmodule

`default_nettype wire

// ==== rtl/ray_core_pkg.sv ====
// --------------------------------------------------
// shared widths, ray and pixel types and the stage
// state encodings for the ray pipeline core
// imported by wildcard into each design unit
// --------------------------------------------------
`default_nettype none

package ray_core_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int COORD_W = 10;
    // direction is signed fixed point, 8 fraction bits
    localparam int FIXED_W = 16;
    localparam int FRAC_W  = 8;
    localparam int CHAN_W  = 8;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [FIXED_W-1:0] fixed_t;
    typedef logic [CHAN_W-1:0]  chan_t;

    // --------------------------------------------------
    // payloads
    // --------------------------------------------------
    // primary ray as it enters the surface stage
    typedef struct packed {
        coord_t       x;
        coord_t       y;
        fixed_t [2:0] dir;
    } ray_in_t;

    // pixel carried from stage to stage
    typedef struct packed {
        coord_t      x;
        coord_t      y;
        chan_t [2:0] colour;
    } pixel_t;

    // stage state machines
    typedef enum logic [1:0] {
        surf_init,
        surf_working,
        surf_done
    } surf_state_t;

    typedef enum logic {
        relay_init,
        relay_done
    } relay_state_t;

endpackage

`default_nettype wire

// ==== rtl/relay_stage.sv ====
// --------------------------------------------------
// one-entry buffered stage that forwards a pixel as is
// used for both the shadow and the shade stage
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module relay_stage
    import ray_core_pkg::*;
(
    input  wire                   clk,
    input  wire                   resetn,
    pixel_stream_if.receiver      in,
    output logic                  out_valid,
    output pixel_t                out_pixel,
    input  logic                  out_full
);

    relay_state_t state;
    logic         buf_full;
    pixel_t       buf_pixel;

    logic         take_in;
    logic         move_in;

    assign take_in = in.valid && !buf_full;
    assign move_in = (state == relay_init) && buf_full;

    assign in.full = buf_full;

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            buf_full  <= 1'b0;
            state     <= relay_init;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;

            if (take_in) begin
                buf_full <= 1'b1;
            end

            case (state)
                relay_init: begin
                    if (buf_full) begin
                        buf_full <= 1'b0;
                        state    <= relay_done;
                    end
                end

                relay_done: begin
                    // waits here under back-pressure, buffer may refill
                    if (!out_full) begin
                        out_valid <= 1'b1;
                        state     <= relay_init;
                    end
                end

                default: begin
                    state <= relay_init;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // payload
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (take_in) begin
            buf_pixel <= in.data;
        end
        // output register loads as done is entered
        if (move_in) begin
            out_pixel <= buf_pixel;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/surface_unit.sv ====
// --------------------------------------------------
// surface stage, entry of the ray pipeline
// buffers one ray, spends SURF_DELAY work cycles on it
// and sends the coloured pixel to the shadow stage
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module surface_unit
    import ray_core_pkg::*;
#(
    parameter int SURF_DELAY = 16
) (
    input  wire                   clk,
    input  wire                   resetn,
    input  logic                  in_valid,
    input  ray_in_t               in_ray,
    output logic                  in_full,
    pixel_stream_if.sender        out
);

    // counter wide enough for SURF_DELAY-1, at least one bit
    localparam int CNT_W = (SURF_DELAY > 1) ? $clog2(SURF_DELAY) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SURF_DELAY - 1);

    surf_state_t      state;
    logic             buf_full;
    logic [CNT_W-1:0] count;

    ray_in_t          buf_ray;
    ray_in_t          work_ray;
    pixel_t           shaded;

    logic             take_in;
    logic             move_in;
    logic             work_end;

    // --------------------------------------------------
    // handshake decodes
    // --------------------------------------------------
    assign take_in  = in_valid && !buf_full;
    assign move_in  = (state == surf_init) && buf_full;
    assign work_end = (state == surf_working) && (count == CNT_LAST);

    assign in_full  = buf_full;

    // integer part of each direction component, low bits kept
    always_comb begin
        shaded.x = work_ray.x;
        shaded.y = work_ray.y;
        for (int i = 0; i < 3; i++) begin
            shaded.colour[i] = chan_t'(work_ray.dir[i] >> FRAC_W);
        end
    end

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            buf_full  <= 1'b0;
            state     <= surf_init;
            count     <= '0;
            out.valid <= 1'b0;
        end else begin
            out.valid <= 1'b0;

            // buffer only fills when empty
            if (take_in) begin
                buf_full <= 1'b1;
            end

            case (state)
                surf_init: begin
                    if (buf_full) begin
                        buf_full <= 1'b0;
                        count    <= '0;
                        state    <= surf_working;
                    end
                end

                surf_working: begin
                    if (work_end) begin
                        state <= surf_done;
                    end else begin
                        count <= count + 1'b1;
                    end
                end

                surf_done: begin
                    // hold the pixel until shadow has room
                    if (!out.full) begin
                        out.valid <= 1'b1;
                        state     <= surf_init;
                    end
                end

                default: begin
                    state <= surf_init;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // payload
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (take_in) begin
            buf_ray <= in_ray;
        end
        if (move_in) begin
            work_ray <= buf_ray;
        end
        // output register loads as done is entered
        if (work_end) begin
            out.data <= shaded;
        end
    end

endmodule

`default_nettype wire

// ==== sim/ray_core_tb.sv ====
// --------------------------------------------------
// testbench for the ray pipeline core
// rays and expected colours come from the trace file
// and outputs are stalled per ray by its hold count
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ray_core_tb
    import ray_core_pkg::*;
();

    localparam int SURF_DELAY = 16;
    localparam int MAX_RAYS   = 64;
    localparam int COLS       = 9;
    localparam int MAX_GAP    = 3;
    // first rays go through one at a time for the latency check
    localparam int ALONE_RAYS = 3;
    // surface needs 2 + delay edges and each relay 3 including the hand-off
    localparam int LATENCY    = 2 + SURF_DELAY + 2 * 3;

    logic    clk;
    logic    resetn;
    logic    in_valid;
    ray_in_t in_ray;
    logic    in_full;
    logic    out_valid;
    pixel_t  out_pixel;
    logic    out_full;

    logic [31:0] trace_mem [0:MAX_RAYS*COLS-1];
    int          accept_edge [MAX_RAYS];
    bit          alone [MAX_RAYS];
    int          in_order [$];

    int cycle = 0;
    int timeout_limit = 0;
    int errors = 0;
    int n_rays = 0;
    int n_out = 0;
    int hold_left = 0;
    int sum_hold = 0;
    bit prev_valid = 1'b0;
    bit saw_stall_full = 1'b0;
    bit latency_checked = 1'b0;

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(3)) u_clk (.clk(clk), .resetn(resetn));

    ray_core #(
        .SURF_DELAY (SURF_DELAY)
    ) uut (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ray    (in_ray),
        .in_full   (in_full),
        .out_valid (out_valid),
        .out_pixel (out_pixel),
        .out_full  (out_full)
    );

    function automatic int trace_word(input int ray, input int col);
        return int'(trace_mem[ray * COLS + col]);
    endfunction

    // integer part of the fixed-point value cut to channel width
    function automatic chan_t channel_from_dir(input fixed_t dir);
        int unsigned whole;
        whole = int'(dir) / (2 ** FRAC_W);
        return chan_t'(whole % (2 ** CHAN_W));
    endfunction

    task automatic check_pixel(input int idx);
        chan_t calc;
        chan_t listed;
        assert (out_pixel.x == coord_t'(trace_word(idx, 0))) else begin
            $display("ERR t=%0t out_pixel.x exp=%0h got=%0h", $time, trace_word(idx, 0),
                     out_pixel.x);
            errors++;
        end
        assert (out_pixel.y == coord_t'(trace_word(idx, 1))) else begin
            $display("ERR t=%0t out_pixel.y exp=%0h got=%0h", $time, trace_word(idx, 1),
                     out_pixel.y);
            errors++;
        end
        for (int c = 0; c < 3; c++) begin
            calc   = channel_from_dir(fixed_t'(trace_word(idx, 2 + c)));
            listed = chan_t'(trace_word(idx, 6 + c));
            assert (out_pixel.colour[c] == listed && out_pixel.colour[c] == calc) else begin
                $display("ERR t=%0t out_pixel.colour[%0d] exp=%0h (rule %0h) got=%0h",
                         $time, c, listed, calc, out_pixel.colour[c]);
                errors++;
            end
        end
    endtask

    // --------------------------------------------------
    // cycle count and run limit
    // --------------------------------------------------
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (timeout_limit > 0 && cycle >= timeout_limit) begin
            $display("timeout after %0d cycles with %0d of %0d pixels out", cycle, n_out, n_rays);
            $display("errors: %0d, pixels out: %0d of %0d", errors + 1, n_out, n_rays);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // output side checks each pixel and then stalls for its hold count
    always @(negedge clk) begin
        int idx;
        int lat;
        if (resetn) begin
            if (out_valid) begin
                assert (!prev_valid) else begin
                    $display("out_valid stayed high for two cycles at %0t", $time);
                    errors++;
                end
                assert (!out_full) else begin
                    $display("out_valid pulsed at %0t while out_full was high", $time);
                    errors++;
                end
                assert (in_order.size() != 0) else begin
                    $display("pixel at %0t arrived with no ray in flight", $time);
                    errors++;
                end
                if (in_order.size() != 0) begin
                    idx = in_order.pop_front();
                    check_pixel(idx);
                    if (alone[idx]) begin
                        lat = cycle - accept_edge[idx];
                        assert (lat == LATENCY) else begin
                            $display("ERR t=%0t out_valid latency exp=%0d got=%0d", $time,
                                     LATENCY, lat);
                            errors++;
                        end
                        latency_checked = 1'b1;
                    end
                    hold_left = trace_word(idx, 5);
                end
                n_out++;
            end
            if (hold_left > 0) begin
                out_full  = 1'b1;
                hold_left = hold_left - 1;
            end else begin
                out_full = 1'b0;
            end
            if (in_full && out_full) begin
                saw_stall_full = 1'b1;
            end
            prev_valid = out_valid;
        end
    end

    // --------------------------------------------------
    // input side
    // --------------------------------------------------
    initial begin
        int gap;
        void'($urandom(32'h9fc0));
        in_valid = 1'b0;
        in_ray   = '0;
        out_full = 1'b0;

        $readmemh("sim/ray_trace.txt", trace_mem);
        while (n_rays < MAX_RAYS && !$isunknown(trace_mem[n_rays * COLS])) begin
            sum_hold += trace_word(n_rays, 5);
            n_rays++;
        end
        assert (n_rays > 0) else begin
            $display("trace file holds no rays");
            errors++;
        end
        timeout_limit = n_rays * (SURF_DELAY + 10 + MAX_GAP) + sum_hold + 100;

        wait (resetn === 1'b1);
        @(negedge clk);
        assert (in_full === 1'b0) else begin
            $display("ERR t=%0t in_full exp=0 got=%b", $time, in_full);
            errors++;
        end
        assert (out_valid === 1'b0) else begin
            $display("ERR t=%0t out_valid exp=0 got=%b", $time, out_valid);
            errors++;
        end

        for (int i = 0; i < n_rays; i++) begin
            if (i < ALONE_RAYS) begin
                while (in_order.size() != 0 || out_full) @(negedge clk);
            end else begin
                gap = $urandom % (MAX_GAP + 1);
                repeat (gap) @(negedge clk);
            end
            while (in_full) @(negedge clk);
            in_valid = 1'b1;
            in_ray.x = coord_t'(trace_word(i, 0));
            in_ray.y = coord_t'(trace_word(i, 1));
            for (int c = 0; c < 3; c++) begin
                in_ray.dir[c] = fixed_t'(trace_word(i, 2 + c));
            end
            alone[i]       = (in_order.size() == 0) && !out_full;
            accept_edge[i] = cycle + 1;
            in_order.push_back(i);
            @(negedge clk);
            in_valid = 1'b0;
        end

        // drain and then watch a little longer for stray pixels
        while (n_out < n_rays) @(negedge clk);
        repeat (LATENCY) @(negedge clk);

        assert (n_out == n_rays) else begin
            $display("ERR t=%0t pixel count exp=%0d got=%0d", $time, n_rays, n_out);
            errors++;
        end
        assert (latency_checked) else begin
            $display("no ray ran alone through the pipeline, latency was not measured");
            errors++;
        end
        assert (sum_hold == 0 || saw_stall_full) else begin
            $display("in_full never rose while the output was stalled");
            errors++;
        end

        $display("errors: %0d, pixels out: %0d of %0d", errors, n_out, n_rays);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/ray_trace.txt ====
// columns, all hex: x y dir0 dir1 dir2 hold col0 col1 col2
// col i is dir i shifted right by 8, low 8 bits; hold is the out_full stall in cycles
000 000 0100 0200 0300 00 01 02 03
3ff 3ff ffff 8000 7fff 00 ff 80 7f
012 034 12ff 00ff 0080 02 12 00 00
001 002 fe80 ff00 8001 28 fe ff 80
100 200 0a55 55aa aa55 00 0a 55 aa
0ab 0cd 7f00 0001 c0de 3c 7f 00 c0
2aa 155 1234 5678 9abc 05 12 56 9a
3fe 001 f00f 0ff0 ff01 00 f0 0f ff
040 080 0000 0000 0000 1e 00 00 00
1ff 200 ffff 0001 fe00 00 ff 00 fe
123 321 4567 89ab cdef 03 45 89 cd
010 020 e123 d456 c789 00 e1 d4 c7
055 0aa 8080 0808 7070 32 80 08 70
2ee 1dd 3c3c c3c3 a5a5 00 3c c3 a5
0f0 00f 0100 ff00 01ff 01 01 ff 01
300 0ff 6000 a000 2000 00 60 a0 20
007 3f8 beef dead cafe 14 be de ca
111 222 ff7f 807f 7f80 00 ff 80 7f
0ff 300 0203 0405 0607 00 02 04 06
3a5 15a fedc ba98 7654 0a fe ba 76
066 099 9999 6666 3333 00 99 66 33
201 102 00ff ff00 8000 00 00 ff 80

// ==== sim/tb_clock_gen.sv ====
// --------------------------------------------------
// testbench clock and reset source
// free-running clock, resetn held low at start
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release away from the active edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/ray_core_pkg.sv
rtl/pixel_stream_if.sv
rtl/surface_unit.sv
rtl/relay_stage.sv
rtl/ray_core.sv
sim/tb_clock_gen.sv
sim/ray_core_tb.sv
